/* hw/pipe_config.svh */
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

`define PIPE_XLEN      32
`define PIPE_NREGS     32
`define PIPE_REG_AW    5
`define PIPE_DM_WORDS  64

// instruction field positions.
`define PIPE_F_OP   31:26
`define PIPE_F_RS   25:21
`define PIPE_F_RT   20:16
`define PIPE_F_RD   15:11
`define PIPE_F_IMM  15:0
`define PIPE_F_SUB  4:0

`endif

/* hw/pipe_pkg.sv */
`include "pipe_config.svh"

package pipe_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'd0,
		OP_ADDI  = 6'd8,
		OP_LW    = 6'd35,
		OP_SW    = 6'd43
	} opcode_t;

	// r-type sub-op values 0 to 4 map straight onto these.
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} alu_op_t;

	typedef struct packed {
		logic    do_reg_write;
		logic    do_dm_read;
		logic    do_dm_write;
		logic    use_imm;
		alu_op_t alu_op;
	} ctrl_t;

	typedef struct packed {
		ctrl_t                   ctrl;
		logic [`PIPE_REG_AW-1:0] rs_addr;
		logic [`PIPE_XLEN-1:0]   rs_data;
		logic [`PIPE_REG_AW-1:0] rt_addr;
		logic [`PIPE_XLEN-1:0]   rt_data;
		logic [`PIPE_XLEN-1:0]   imm;
		logic [`PIPE_REG_AW-1:0] wa;
	} id_ex_t;

	typedef struct packed {
		ctrl_t                   ctrl;
		logic [`PIPE_XLEN-1:0]   alu_result;
		logic [`PIPE_XLEN-1:0]   store_data;
		logic [`PIPE_REG_AW-1:0] wa;
	} ex_mem_t;

	typedef struct packed {
		logic                    do_reg_write;
		logic [`PIPE_REG_AW-1:0] wa;
		logic [`PIPE_XLEN-1:0]   wd;
	} mem_wb_t;

endpackage

/* hw/fwd_if.sv */
`timescale 1ns/1ps
`include "pipe_config.svh"

interface fwd_if;
	logic                    id_ex_load;
	logic [`PIPE_REG_AW-1:0] id_ex_wa;

	logic                    ex_mem_we;
	logic [`PIPE_REG_AW-1:0] ex_mem_wa;
	logic [`PIPE_XLEN-1:0]   ex_mem_result;

	logic                    wb_we;
	logic [`PIPE_REG_AW-1:0] wb_wa;
	logic [`PIPE_XLEN-1:0]   wb_wd;

	modport walls (
		output id_ex_load, id_ex_wa,
		output ex_mem_we, ex_mem_wa, ex_mem_result,
		output wb_we, wb_wa, wb_wd
	);

	modport dec (input id_ex_load, id_ex_wa);

	modport exe (input ex_mem_we, ex_mem_wa, ex_mem_result, wb_we, wb_wa, wb_wd);
endinterface

/* hw/reg_file.sv */
`timescale 1ns/1ps
`include "pipe_config.svh"

module reg_file (
	input  logic                    clock,
	input  logic                    reset,
	input  logic [`PIPE_REG_AW-1:0] rs_addr,
	input  logic [`PIPE_REG_AW-1:0] rt_addr,
	output logic [`PIPE_XLEN-1:0]   rs_data,
	output logic [`PIPE_XLEN-1:0]   rt_data,
	input  logic                    we,
	input  logic [`PIPE_REG_AW-1:0] wa,
	input  logic [`PIPE_XLEN-1:0]   wd
);
	// register 0 has no storage.
	logic [`PIPE_XLEN-1:0] regs [1:`PIPE_NREGS-1];

	function automatic logic [`PIPE_XLEN-1:0] read_port(input logic [`PIPE_REG_AW-1:0] a);
		if (a == '0)
			return '0;
		else if (we && wa == a)
			return wd;
		else
			return regs[a];
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < `PIPE_NREGS; i++)
				regs[i] <= '0;
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	always_comb begin
		rs_data = read_port(rs_addr);
		rt_data = read_port(rt_addr);
	end
endmodule

/* hw/decode_unit.sv */
`timescale 1ns/1ps
`include "pipe_config.svh"

module decode_unit (
	input  logic                  clock,
	input  logic                  reset,
	input  logic [`PIPE_XLEN-1:0] instr,
	input  pipe_pkg::mem_wb_t     wb,
	fwd_if.dec                    fwd,
	output pipe_pkg::id_ex_t      payload,
	output logic                  hazard
);
	import pipe_pkg::*;

	opcode_t                 op;
	logic [`PIPE_REG_AW-1:0] rs_addr;
	logic [`PIPE_REG_AW-1:0] rt_addr;
	logic [`PIPE_REG_AW-1:0] rd_addr;
	logic [4:0]              sub_op;
	logic [`PIPE_XLEN-1:0]   rs_data;
	logic [`PIPE_XLEN-1:0]   rt_data;
	ctrl_t                   ctrl;
	logic [`PIPE_REG_AW-1:0] wa;

	assign op      = opcode_t'(instr[`PIPE_F_OP]);
	assign rs_addr = instr[`PIPE_F_RS];
	assign rt_addr = instr[`PIPE_F_RT];
	assign rd_addr = instr[`PIPE_F_RD];
	assign sub_op  = instr[`PIPE_F_SUB];

	reg_file u_reg_file (
		.clock   (clock),
		.reset   (reset),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.we      (wb.do_reg_write),
		.wa      (wb.wa),
		.wd      (wb.wd)
	);

	always_comb begin
		ctrl = '0;
		wa   = '0;
		case (op)
			OP_RTYPE: begin
				// the all-zero word is a no-op, not a write to r0.
				if (instr != '0) begin
					ctrl.do_reg_write = 1'b1;
					if (sub_op <= 5'd4)
						ctrl.alu_op = alu_op_t'(sub_op[2:0]);
					wa = rd_addr;
				end
			end
			OP_ADDI: begin
				ctrl.do_reg_write = 1'b1;
				ctrl.use_imm      = 1'b1;
				wa                = rt_addr;
			end
			OP_LW: begin
				ctrl.do_reg_write = 1'b1;
				ctrl.do_dm_read   = 1'b1;
				ctrl.use_imm      = 1'b1;
				wa                = rt_addr;
			end
			OP_SW: begin
				ctrl.do_dm_write = 1'b1;
				ctrl.use_imm     = 1'b1;
			end
			default: ;
		endcase
	end

	always_comb begin
		payload         = '0;
		payload.ctrl    = ctrl;
		payload.rs_addr = rs_addr;
		payload.rs_data = rs_data;
		payload.rt_addr = rt_addr;
		payload.rt_data = rt_data;
		payload.imm     = `PIPE_XLEN'(signed'(instr[`PIPE_F_IMM]));
		payload.wa      = wa;
	end

	// a load one slot ahead cannot forward in time.
	assign hazard = fwd.id_ex_load && fwd.id_ex_wa != '0 &&
		(fwd.id_ex_wa == rs_addr || fwd.id_ex_wa == rt_addr);

	a_imm_wa: assert property (@(posedge clock) disable iff (reset)
		(ctrl.do_reg_write && (op == OP_ADDI || op == OP_LW) && rt_addr != '0)
		|-> payload.wa != '0);
endmodule

/* hw/pipe_walls.sv */
`timescale 1ns/1ps
`include "pipe_config.svh"

module pipe_walls (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  enable,
	input  logic                  flush,
	input  logic                  hazard,
	input  logic [`PIPE_XLEN-1:0] instr_in,
	output logic [`PIPE_XLEN-1:0] instr_out,
	input  pipe_pkg::id_ex_t      id_ex_in,
	output pipe_pkg::id_ex_t      id_ex_out,
	input  pipe_pkg::ex_mem_t     ex_mem_in,
	output pipe_pkg::ex_mem_t     ex_mem_out,
	input  pipe_pkg::mem_wb_t     mem_wb_in,
	output pipe_pkg::mem_wb_t     mem_wb_out,
	fwd_if.walls                  fwd
);
	import pipe_pkg::*;

	logic [`PIPE_XLEN-1:0] instr_q;
	id_ex_t                id_ex_q;
	ex_mem_t               ex_mem_q;
	mem_wb_t               mem_wb_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			instr_q  <= '0;
			id_ex_q  <= '0;
			ex_mem_q <= '0;
			mem_wb_q <= '0;
		end else if (enable) begin
			// hazard wins over flush.
			if (hazard)
				instr_q <= instr_q;
			else if (flush)
				instr_q <= '0;
			else
				instr_q <= instr_in;

			if (hazard)
				id_ex_q <= '0;
			else
				id_ex_q <= id_ex_in;

			ex_mem_q <= ex_mem_in;
			mem_wb_q <= mem_wb_in;
		end
	end

	assign instr_out  = instr_q;
	assign id_ex_out  = id_ex_q;
	assign ex_mem_out = ex_mem_q;

	// the write-back entry retires only in a cycle where the walls advance.
	always_comb begin
		mem_wb_out              = mem_wb_q;
		mem_wb_out.do_reg_write = mem_wb_q.do_reg_write && enable;
	end

	assign fwd.id_ex_load = id_ex_q.ctrl.do_dm_read;
	assign fwd.id_ex_wa   = id_ex_q.wa;

	// a load's alu result is an address, so it never forwards.
	assign fwd.ex_mem_we     = ex_mem_q.ctrl.do_reg_write && !ex_mem_q.ctrl.do_dm_read;
	assign fwd.ex_mem_wa     = ex_mem_q.wa;
	assign fwd.ex_mem_result = ex_mem_q.alu_result;

	assign fwd.wb_we = mem_wb_q.do_reg_write;
	assign fwd.wb_wa = mem_wb_q.wa;
	assign fwd.wb_wd = mem_wb_q.wd;

	// the bubble reaches the execute/memory wall with no enables set.
	a_bubble: assert property (@(posedge clock) disable iff (reset)
		(enable && $past(enable && hazard)) |=> (ex_mem_q.ctrl == '0));

	// with the walls frozen the stage logic between them holds still.
	a_frozen: assert property (@(posedge clock) disable iff (reset)
		!enable |=> ($stable(ex_mem_in) && $stable(mem_wb_in)));
endmodule

/* hw/execute_unit.sv */
`timescale 1ns/1ps
`include "pipe_config.svh"

module execute_unit (
	input  pipe_pkg::id_ex_t  in,
	fwd_if.exe                fwd,
	output pipe_pkg::ex_mem_t out
);
	import pipe_pkg::*;

	logic [`PIPE_XLEN-1:0] rs_val;
	logic [`PIPE_XLEN-1:0] rt_val;
	logic [`PIPE_XLEN-1:0] src_b;
	logic [`PIPE_XLEN-1:0] result;

	// execute/memory first, then write-back, then the register file.
	function automatic logic [`PIPE_XLEN-1:0] pick(
		input logic [`PIPE_REG_AW-1:0] a,
		input logic [`PIPE_XLEN-1:0]   rf_data
	);
		if (a == '0)
			return rf_data;
		else if (fwd.ex_mem_we && fwd.ex_mem_wa == a)
			return fwd.ex_mem_result;
		else if (fwd.wb_we && fwd.wb_wa == a)
			return fwd.wb_wd;
		else
			return rf_data;
	endfunction

	always_comb begin
		rs_val = pick(in.rs_addr, in.rs_data);
		rt_val = pick(in.rt_addr, in.rt_data);
	end

	assign src_b  = in.ctrl.use_imm ? in.imm : rt_val;

	always_comb begin
		case (in.ctrl.alu_op)
			ALU_SUB: result = rs_val - src_b;
			ALU_AND: result = rs_val & src_b;
			ALU_OR:  result = rs_val | src_b;
			ALU_SLT: result = `PIPE_XLEN'($signed(rs_val) < $signed(src_b));
			default: result = rs_val + src_b;
		endcase
	end

	always_comb begin
		out            = '0;
		out.ctrl       = in.ctrl;
		out.alu_result = result;
		out.store_data = rt_val;
		out.wa         = in.wa;
	end
endmodule

/* hw/mem_unit.sv */
`timescale 1ns/1ps
`include "pipe_config.svh"

module mem_unit (
	input  logic              clock,
	input  logic              reset,
	input  pipe_pkg::ex_mem_t in,
	output pipe_pkg::mem_wb_t out
);
	import pipe_pkg::*;

	localparam int DM_AW = $clog2(`PIPE_DM_WORDS);

	logic [`PIPE_XLEN-1:0] dm [`PIPE_DM_WORDS];
	logic [DM_AW-1:0]      word_addr;
	logic [`PIPE_XLEN-1:0] rdata;

	// word index, byte offset bits dropped.
	assign word_addr = in.alu_result[DM_AW+1:2];
	assign rdata     = dm[word_addr];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `PIPE_DM_WORDS; i++)
				dm[i] <= '0;
		end else if (in.ctrl.do_dm_write) begin
			dm[word_addr] <= in.store_data;
		end
	end

	always_comb begin
		out              = '0;
		out.do_reg_write = in.ctrl.do_reg_write;
		out.wa           = in.wa;
		out.wd           = in.ctrl.do_dm_read ? rdata : in.alu_result;
	end

	a_rw_excl: assert property (@(posedge clock) disable iff (reset)
		!(in.ctrl.do_dm_read && in.ctrl.do_dm_write));
endmodule

/* hw/pipe_top.sv */
`timescale 1ns/1ps
`include "pipe_config.svh"

module pipe_top (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    enable,
	input  logic                    flush,
	input  logic [`PIPE_XLEN-1:0]   instr,
	output logic                    stall,
	output logic                    wb_en,
	output logic [`PIPE_REG_AW-1:0] wb_addr,
	output logic [`PIPE_XLEN-1:0]   wb_data
);
	import pipe_pkg::*;

	logic [`PIPE_XLEN-1:0] fetch_instr;
	logic                  hazard;
	id_ex_t                id_ex_d;
	id_ex_t                id_ex_q;
	ex_mem_t               ex_mem_d;
	ex_mem_t               ex_mem_q;
	mem_wb_t               mem_wb_d;
	mem_wb_t               mem_wb_q;

	fwd_if fwd ();

	decode_unit u_decode (
		.clock   (clock),
		.reset   (reset),
		.instr   (fetch_instr),
		.wb      (mem_wb_q),
		.fwd     (fwd.dec),
		.payload (id_ex_d),
		.hazard  (hazard)
	);

	pipe_walls u_walls (
		.clock      (clock),
		.reset      (reset),
		.enable     (enable),
		.flush      (flush),
		.hazard     (hazard),
		.instr_in   (instr),
		.instr_out  (fetch_instr),
		.id_ex_in   (id_ex_d),
		.id_ex_out  (id_ex_q),
		.ex_mem_in  (ex_mem_d),
		.ex_mem_out (ex_mem_q),
		.mem_wb_in  (mem_wb_d),
		.mem_wb_out (mem_wb_q),
		.fwd        (fwd.walls)
	);

	execute_unit u_execute (
		.in  (id_ex_q),
		.fwd (fwd.exe),
		.out (ex_mem_d)
	);

	mem_unit u_mem (
		.clock (clock),
		.reset (reset),
		.in    (ex_mem_q),
		.out   (mem_wb_d)
	);

	assign stall   = hazard;
	assign wb_en   = mem_wb_q.do_reg_write;
	assign wb_addr = mem_wb_q.wa;
	assign wb_data = mem_wb_q.wd;
endmodule

/* tb/tb_table.svh */
`ifndef TB_TABLE_SVH
`define TB_TABLE_SVH

// columns: instruction word, flush bit, enable-low cycles before the row, test name.
task automatic build_table();
	// independent alu ops.
	add_row(i_type(OPC_ADDI, 5'd1, 5'd0, 16'd5),     1'b0, 0, "addi_r1");
	add_row(i_type(OPC_ADDI, 5'd2, 5'd0, 16'hfffd),  1'b0, 0, "addi_r2_neg");
	add_row(i_type(OPC_ADDI, 5'd3, 5'd0, 16'd12),    1'b0, 0, "addi_r3");
	add_row(i_type(OPC_ADDI, 5'd4, 5'd0, 16'd10),    1'b0, 0, "addi_r4");
	add_row(r_type(5'd5, 5'd1, 5'd3, SUB_ADD),       1'b0, 0, "add_r5");
	add_row(r_type(5'd6, 5'd3, 5'd4, SUB_SUB),       1'b0, 0, "sub_r6");
	add_row(r_type(5'd7, 5'd3, 5'd4, SUB_AND),       1'b0, 0, "and_r7");
	add_row(r_type(5'd8, 5'd3, 5'd4, SUB_OR),        1'b0, 0, "or_r8");
	add_row(r_type(5'd9, 5'd2, 5'd1, SUB_SLT),       1'b0, 0, "slt_r9");
	// back-to-back dependencies.
	add_row(i_type(OPC_ADDI, 5'd10, 5'd0, 16'd7),    1'b0, 0, "addi_r10");
	add_row(r_type(5'd11, 5'd10, 5'd10, SUB_ADD),    1'b0, 0, "fwd_exmem");
	add_row(r_type(5'd12, 5'd11, 5'd10, SUB_SUB),    1'b0, 0, "fwd_both");
	add_row(r_type(5'd13, 5'd12, 5'd11, SUB_OR),     1'b0, 0, "fwd_wb");
	// store, load and load-use.
	add_row(i_type(OPC_ADDI, 5'd14, 5'd0, 16'h0040), 1'b0, 0, "addi_base");
	add_row(i_type(OPC_SW, 5'd12, 5'd14, 16'd4),     1'b0, 0, "sw_r12");
	add_row(i_type(OPC_LW, 5'd15, 5'd14, 16'd4),     1'b0, 0, "lw_r15");
	add_row(r_type(5'd16, 5'd15, 5'd1, SUB_ADD),     1'b0, 0, "use_rs");
	add_row(i_type(OPC_LW, 5'd17, 5'd14, 16'd4),     1'b0, 0, "lw_r17");
	add_row(r_type(5'd18, 5'd1, 5'd17, SUB_SUB),     1'b0, 0, "use_rt");
	// flushed word, offered while the load-use stall is still up.
	add_row(i_type(OPC_ADDI, 5'd1, 5'd0, 16'd99),    1'b1, 0, "flushed");
	add_row(r_type(5'd19, 5'd1, 5'd0, SUB_ADD),      1'b0, 0, "after_flush");
	// enable-low gaps and register 0.
	add_row(i_type(OPC_ADDI, 5'd20, 5'd1, 16'd100),  1'b0, 2, "gap_addi");
	add_row(r_type(5'd21, 5'd20, 5'd5, SUB_ADD),     1'b0, RAND_GAP, "gap_fwd");
	add_row(i_type(OPC_ADDI, 5'd0, 5'd0, 16'd55),    1'b0, 0, "addi_r0");
	add_row(r_type(5'd0, 5'd1, 5'd3, SUB_ADD),       1'b0, 1, "add_r0");
	add_row(r_type(5'd22, 5'd0, 5'd1, SUB_ADD),      1'b0, 0, "read_r0");
	add_row(32'd0,                                   1'b0, RAND_GAP, "nop");
	add_row(i_type(OPC_LW, 5'd23, 5'd14, 16'd4),     1'b0, 0, "lw_r23");
	add_row(r_type(5'd24, 5'd23, 5'd23, SUB_OR),     1'b0, RAND_GAP, "gap_load_use");
endtask

`endif

/* tb/tb_pipe.sv */
`timescale 1ns/1ps
`include "pipe_config.svh"

module tb_pipe;
	localparam int STALL_LIMIT = 16;
	localparam int DRAIN_LIMIT = 64;
	// gap column value that asks for a random gap.
	localparam int RAND_GAP = -1;

	localparam logic [5:0] OPC_RTYPE = 6'd0;
	localparam logic [5:0] OPC_ADDI  = 6'd8;
	localparam logic [5:0] OPC_LW    = 6'd35;
	localparam logic [5:0] OPC_SW    = 6'd43;

	localparam logic [4:0] SUB_ADD = 5'd0;
	localparam logic [4:0] SUB_SUB = 5'd1;
	localparam logic [4:0] SUB_AND = 5'd2;
	localparam logic [4:0] SUB_OR  = 5'd3;
	localparam logic [4:0] SUB_SLT = 5'd4;

	logic        clock;
	logic        reset;
	logic        enable;
	logic        flush;
	logic [31:0] instr;
	logic        stall;
	logic        wb_en;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;

	// stimulus rows.
	logic [31:0] row_word[$];
	logic        row_flush[$];
	int          row_gap[$];
	string       row_name[$];

	// expected write-backs, oldest first.
	logic [4:0]  exp_addr[$];
	logic [31:0] exp_data[$];
	string       exp_name[$];

	logic [31:0] model_regs [`PIPE_NREGS];
	logic [31:0] model_mem [`PIPE_DM_WORDS];

	// words in the fetch and decode/execute walls, flushed ones as zero.
	logic [31:0] fetch_word;
	logic [31:0] id_word;

	pipe_top DUT (
		.clock   (clock),
		.reset   (reset),
		.enable  (enable),
		.flush   (flush),
		.instr   (instr),
		.stall   (stall),
		.wb_en   (wb_en),
		.wb_addr (wb_addr),
		.wb_data (wb_data)
	);

	always #4 clock = ~clock;

	function automatic logic [31:0] r_type(input logic [4:0] rd, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] sub);
		return {OPC_RTYPE, rs, rt, rd, 6'd0, sub};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// a load whose target the next word reads as rs or rt.
	function automatic logic load_use(input logic [31:0] older, input logic [31:0] younger);
		return older[31:26] == OPC_LW && older[20:16] != 5'd0 &&
			(older[20:16] == younger[25:21] || older[20:16] == younger[20:16]);
	endfunction

	task automatic add_row(input logic [31:0] word, input logic fl, input int gap,
		input string name);
		row_word.push_back(word);
		row_flush.push_back(fl);
		row_gap.push_back(gap);
		row_name.push_back(name);
	endtask

	`include "tb_table.svh"

	task automatic report_failure();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic model_write(input logic [4:0] wa, input logic [31:0] wd, input string name);
		exp_addr.push_back(wa);
		exp_data.push_back(wd);
		exp_name.push_back(name);
		// r0 shows on the bus but keeps reading zero.
		if (wa != 5'd0)
			model_regs[wa] = wd;
	endtask

	task automatic model_exec(input logic [31:0] word, input string name);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [31:0] v;
		a    = model_regs[word[25:21]];
		b    = model_regs[word[20:16]];
		imm  = {{16{word[15]}}, word[15:0]};
		addr = a + imm;
		case (word[31:26])
			OPC_RTYPE: begin
				if (word != 32'd0) begin
					case (word[4:0])
						SUB_SUB: v = a - b;
						SUB_AND: v = a & b;
						SUB_OR:  v = a | b;
						SUB_SLT: v = {31'd0, $signed(a) < $signed(b)};
						default: v = a + b;
					endcase
					model_write(word[15:11], v, name);
				end
			end
			OPC_ADDI: model_write(word[20:16], addr, name);
			OPC_LW:   model_write(word[20:16], model_mem[addr[7:2]], name);
			OPC_SW:   model_mem[addr[7:2]] = b;
			default: ;
		endcase
	endtask

	task automatic apply_row(input int idx);
		int gap;
		int g;
		int waited;
		int exp_wait;
		gap = row_gap[idx];
		if (gap == RAND_GAP)
			gap = int'($urandom_range(3, 1));
		for (g = 0; g < gap; g++) begin
			enable <= 1'b0;
			@(posedge clock);
		end
		enable <= 1'b1;
		flush  <= row_flush[idx];
		instr  <= row_word[idx];
		// the word is taken at the first edge that follows a cycle with stall low.
		waited = 0;
		@(negedge clock);
		while (stall) begin
			waited++;
			assert (waited < STALL_LIMIT) else begin
				$display("stall stayed high for %0d cycles at row %s", waited, row_name[idx]);
				report_failure();
			end
			@(negedge clock);
		end
		exp_wait = load_use(id_word, fetch_word) ? 1 : 0;
		assert (waited == exp_wait) else begin
			$display("Fail %s: stall cycles expected %0d, actual %0d", row_name[idx],
				exp_wait, waited);
			report_failure();
		end
		@(posedge clock);
		id_word    = fetch_word;
		fetch_word = row_flush[idx] ? 32'd0 : row_word[idx];
		if (!row_flush[idx])
			model_exec(row_word[idx], row_name[idx]);
	endtask

	task automatic check_wb();
		logic [4:0]  ea;
		logic [31:0] ed;
		string       name;
		assert (exp_addr.size() > 0) else begin
			$display("write-back to r%0d with data %h came with none expected", wb_addr, wb_data);
			report_failure();
		end
		ea   = exp_addr.pop_front();
		ed   = exp_data.pop_front();
		name = exp_name.pop_front();
		assert (wb_addr == ea) else begin
			$display("Fail %s: wb_addr expected %0d, actual %0d", name, ea, wb_addr);
			report_failure();
		end
		assert (wb_data == ed) else begin
			$display("Fail %s: wb_data expected %h, actual %h", name, ed, wb_data);
			report_failure();
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_addr.size() > 0) begin
			waited++;
			assert (waited < DRAIN_LIMIT) else begin
				$display("%0d write-backs still missing after %0d cycles", exp_addr.size(), waited);
				report_failure();
			end
			@(posedge clock);
		end
	endtask

	// outputs are stable at the falling edge.
	always @(negedge clock) begin
		if (!reset && wb_en)
			check_wb();
	end

	initial begin
		int idx;
		void'($urandom(77));
		clock  = 1'b0;
		reset  = 1'b1;
		enable = 1'b0;
		flush  = 1'b0;
		instr  = '0;
		fetch_word = '0;
		id_word    = '0;
		for (idx = 0; idx < `PIPE_NREGS; idx++)
			model_regs[idx] = '0;
		for (idx = 0; idx < `PIPE_DM_WORDS; idx++)
			model_mem[idx] = '0;
		build_table();

		repeat (8) @(posedge clock);
		reset <= 1'b0;
		for (idx = 0; idx < row_word.size(); idx++)
			apply_row(idx);
		instr  <= '0;
		flush  <= 1'b0;
		enable <= 1'b1;
		wait_drain();
		// idle a little so a stray write-back still gets caught.
		repeat (4) @(posedge clock);
		$display("No errors");
		$finish;
	end
endmodule

/* list.f */
+incdir+hw
+incdir+tb
hw/pipe_pkg.sv
hw/fwd_if.sv
hw/reg_file.sv
hw/decode_unit.sv
hw/pipe_walls.sv
hw/execute_unit.sv
hw/mem_unit.sv
hw/pipe_top.sv
tb/tb_pipe.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := tb_pipe
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "No errors" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
